//--- rtl/ppu_out_defines.svh
// Fixed 8-bit RGB format and 2-stage PAL synchronizer; the range pipeline depth is not tunable
`ifndef PPU_OUT_DEFINES_SVH
`define PPU_OUT_DEFINES_SVH

// ============================================================
// Pixel format
// ============================================================

// Bits per colour channel
`define PPU_COLOR_W 8

// Limited range is 16..235, so 220 steps over a 256 scale
`define PPU_LIM_COEFF 8'd220
`define PPU_LIM_OFFSET 8'd16

// ============================================================
// Latencies
// ============================================================

// Flops on the asynchronous PAL flag before decode
`define PPU_SYNC_STAGES 2

// Pixel latency from pix_i to the output ports
`define PPU_PIPE_DEPTH 3

`endif

//--- rtl/ppu_out_pkg.sv
// Type widths follow the 8-bit format in the defines header; cfg word is assumed quasi-static
`default_nettype none

`include "ppu_out_defines.svh"

package ppu_out_pkg;

  // Requested output target
  typedef enum logic [2:0] {
    RES_240P  = 3'd0,
    RES_288P  = 3'd1,
    RES_480P  = 3'd2,
    RES_576P  = 3'd3,
    RES_720P  = 3'd4,
    RES_960P  = 3'd5,
    RES_1080P = 3'd6,
    RES_1200P = 3'd7
  } target_res_e;

  // Resolved output mode, 60 Hz modes first
  typedef enum logic [3:0] {
    VM_240P60  = 4'd0,
    VM_480P60  = 4'd1,
    VM_VGAP60  = 4'd2,
    VM_720P60  = 4'd3,
    VM_960P60  = 4'd4,
    VM_1080P60 = 4'd5,
    VM_1200P60 = 4'd6,
    VM_288P50  = 4'd7,
    VM_576P50  = 4'd8,
    VM_720P50  = 4'd9,
    VM_960P50  = 4'd10,
    VM_1080P50 = 4'd11,
    VM_1200P50 = 4'd12
  } vmode_e;

  typedef struct packed {
    target_res_e target_res;
    logic        use_vga;
    logic        force60;
    logic        force50;
    logic        llm;
    logic        limited_rgb;
  } ppu_cfg_t;

  typedef struct packed {
    logic [`PPU_COLOR_W-1:0] red;
    logic [`PPU_COLOR_W-1:0] green;
    logic [`PPU_COLOR_W-1:0] blue;
  } rgb_t;

  // Syncs on the input side are always active high
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t color;
  } pix_t;

  typedef struct packed {
    vmode_e vmode;
    logic   vsync_act_high;
    logic   hsync_act_high;
    logic   limited_rgb;
  } out_cfg_t;

endpackage

`default_nettype wire

//--- rtl/ppu_cfg_decode.sv
// palmode_i may be asynchronous to VCLK_Tx; cfg_i must be held stable while in use
`default_nettype none
`timescale 1ns/1ns

`include "ppu_out_defines.svh"

module ppu_cfg_decode
  import ppu_out_pkg::*;
(
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  ppu_cfg_t cfg_i,
  input  logic     palmode_i,
  output out_cfg_t out_cfg_o
);

  logic [`PPU_SYNC_STAGES-1:0] pal_sync;
  logic                        pal_synced;
  vmode_e                      vmode_ntsc;
  vmode_e                      vmode_pal;
  vmode_e                      vmode_sel;
  logic                        force60_ok;
  logic                        force50_ok;
  logic                        sync_high;

  // ============================================================
  // PAL flag synchronizer
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pal_sync <= '0;
    end else begin
      pal_sync <= {pal_sync[`PPU_SYNC_STAGES-2:0], palmode_i};
    end
  end

  assign pal_synced = pal_sync[`PPU_SYNC_STAGES-1];

  // ============================================================
  // Mode mapping per side
  // ============================================================

  always_comb begin
    case (cfg_i.target_res)
      RES_240P, RES_288P: vmode_ntsc = VM_240P60;
      RES_480P, RES_576P: vmode_ntsc = cfg_i.use_vga ? VM_VGAP60 : VM_480P60;
      RES_720P:           vmode_ntsc = VM_720P60;
      RES_960P:           vmode_ntsc = VM_960P60;
      RES_1080P:          vmode_ntsc = VM_1080P60;
      RES_1200P:          vmode_ntsc = VM_1200P60;
      default:            vmode_ntsc = VM_480P60;
    endcase
  end

  // No VGA flavour on the 50 Hz side
  always_comb begin
    case (cfg_i.target_res)
      RES_240P, RES_288P: vmode_pal = VM_288P50;
      RES_480P, RES_576P: vmode_pal = VM_576P50;
      RES_720P:           vmode_pal = VM_720P50;
      RES_960P:           vmode_pal = VM_960P50;
      RES_1080P:          vmode_pal = VM_1080P50;
      RES_1200P:          vmode_pal = VM_1200P50;
      default:            vmode_pal = VM_576P50;
    endcase
  end

  // Forcing is blocked in LLM and for the opposite fixed low-res target
  assign force60_ok = cfg_i.force60 && !cfg_i.llm && (cfg_i.target_res != RES_288P);
  assign force50_ok = cfg_i.force50 && !cfg_i.llm && (cfg_i.target_res != RES_240P);

  always_comb begin
    if (force60_ok) begin
      vmode_sel = vmode_ntsc;
    end else if (force50_ok) begin
      vmode_sel = vmode_pal;
    end else begin
      vmode_sel = pal_synced ? vmode_pal : vmode_ntsc;
    end
  end

  // HD modes use positive syncs
  always_comb begin
    case (vmode_sel)
      VM_720P60, VM_960P60, VM_1080P60, VM_1200P60,
      VM_720P50, VM_960P50, VM_1080P50, VM_1200P50: sync_high = 1'b1;
      default:                                      sync_high = 1'b0;
    endcase
  end

  // ============================================================
  // Decode register
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      out_cfg_o.vmode          <= VM_480P60;
      out_cfg_o.vsync_act_high <= 1'b0;
      out_cfg_o.hsync_act_high <= 1'b0;
      out_cfg_o.limited_rgb    <= 1'b0;
    end else begin
      out_cfg_o.vmode          <= vmode_sel;
      out_cfg_o.vsync_act_high <= sync_high;
      out_cfg_o.hsync_act_high <= sync_high;
      out_cfg_o.limited_rgb    <= cfg_i.limited_rgb;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ppu_range_out.sv
// Fixed 3-cycle latency, no stall; range and sync polarity follow out_cfg_i at the last stage
`default_nettype none
`timescale 1ns/1ns

`include "ppu_out_defines.svh"

module ppu_range_out
  import ppu_out_pkg::*;
(
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  pix_t     pix_i,
  input  out_cfg_t out_cfg_i,
  output logic     vsync_o,
  output logic     hsync_o,
  output logic     de_o,
  output rgb_t     vd_o
);

  // Channel 2 is red, 0 is blue, as in rgb_t
  logic [2:0][`PPU_COLOR_W-1:0]   chan_in;
  logic [2:0][2*`PPU_COLOR_W-1:0] prod;
  logic [2:0][`PPU_COLOR_W:0]     lim_s1;
  logic [2:0][`PPU_COLOR_W-1:0]   lim_s2;
  logic [2:0][`PPU_COLOR_W-1:0]   lim_off;
  rgb_t                           full_s1;
  rgb_t                           full_s2;

  // {vsync, hsync, de} ahead of the output register
  logic [`PPU_PIPE_DEPTH-2:0][2:0] ctrl_dly;
  logic [2:0]                      ctrl_last;

  assign chan_in = pix_i.color;

  // ============================================================
  // Colour path
  // ============================================================

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i]    = chan_in[i] * `PPU_LIM_COEFF;
      lim_off[i] = lim_s2[i] + `PPU_LIM_OFFSET;
    end
  end

  // Stage 1 keeps product / 128, stage 2 halves it with round half up
  always_ff @(posedge VCLK_Tx) begin
    for (int i = 0; i < 3; i++) begin
      lim_s1[i] <= prod[i][2*`PPU_COLOR_W-1:`PPU_COLOR_W-1];
      lim_s2[i] <= lim_s1[i][`PPU_COLOR_W:1] + `PPU_COLOR_W'(lim_s1[i][0]);
    end
    full_s1 <= pix_i.color;
    full_s2 <= full_s1;
  end

  // ============================================================
  // Control path
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      ctrl_dly <= '0;
    end else begin
      ctrl_dly[0] <= {pix_i.vsync, pix_i.hsync, pix_i.de};
      for (int k = 1; k < `PPU_PIPE_DEPTH-1; k++) begin
        ctrl_dly[k] <= ctrl_dly[k-1];
      end
    end
  end

  assign ctrl_last = ctrl_dly[`PPU_PIPE_DEPTH-2];

  // ============================================================
  // Output register
  // ============================================================

  // Reset polarity is active low, so idle syncs sit high
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vsync_o <= 1'b1;
      hsync_o <= 1'b1;
      de_o    <= 1'b0;
      vd_o    <= '0;
    end else begin
      vsync_o <= out_cfg_i.vsync_act_high ? ctrl_last[2] : ~ctrl_last[2];
      hsync_o <= out_cfg_i.hsync_act_high ? ctrl_last[1] : ~ctrl_last[1];
      de_o    <= ctrl_last[0];
      if (out_cfg_i.limited_rgb) begin
        vd_o <= rgb_t'(lim_off);
      end else begin
        vd_o <= full_s2;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ppu_out_top.sv
// Single VCLK_Tx domain; pixels take 3 cycles, a new cfg settles within 3 cycles
`default_nettype none
`timescale 1ns/1ns

module ppu_out_top
  import ppu_out_pkg::*;
(
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  ppu_cfg_t cfg_i,
  input  logic     palmode_i,
  input  pix_t     pix_i,
  output vmode_e   vmode_o,
  output logic     vsync_o,
  output logic     hsync_o,
  output logic     de_o,
  output rgb_t     vd_o
);

  // Decoded mode, polarities and range flag
  out_cfg_t out_cfg;

  // ============================================================
  // Mode decode
  // ============================================================

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .cfg_i     (cfg_i),
    .palmode_i (palmode_i),
    .out_cfg_o (out_cfg)
  );

  // ============================================================
  // Pixel output pipeline
  // ============================================================

  ppu_range_out u_range_out (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .pix_i     (pix_i),
    .out_cfg_i (out_cfg),
    .vsync_o   (vsync_o),
    .hsync_o   (hsync_o),
    .de_o      (de_o),
    .vd_o      (vd_o)
  );

  // Mode goes out for the HDMI transmitter setup
  assign vmode_o = out_cfg.vmode;

endmodule

`default_nettype wire

//--- verif/ppu_out_asserts.sv
// Bound into every ppu_range_out; the latency check assumes 3 cycles and a settled reset
`default_nettype none
`timescale 1ns/1ns

module ppu_out_asserts
  import ppu_out_pkg::*;
(
  input logic     VCLK_Tx,
  input logic     nVRST_Tx,
  input pix_t     pix_i,
  input out_cfg_t out_cfg_i,
  input logic     de_i,
  input rgb_t     vd_i
);

  // Failure tally, read at the end of the run
  int unsigned fail_cnt = 0;

  // Cycles out of reset, saturating once the pipeline is full
  logic [1:0] run_cnt;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      run_cnt <= '0;
    end else if (run_cnt != 2'd3) begin
      run_cnt <= run_cnt + 2'd1;
    end
  end

  de_low_in_reset: assert property (@(posedge VCLK_Tx) !nVRST_Tx |-> !de_i)
    else begin
      $error("de_o high while reset is asserted");
      fail_cnt++;
    end

  de_latency: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (run_cnt == 2'd3) |-> (de_i == $past(pix_i.de, 3)))
    else begin
      $error("de_o does not match pix_i.de from 3 cycles earlier");
      fail_cnt++;
    end

  // Output stage used the range flag seen one edge back
  limited_bounds: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (run_cnt == 2'd3) && $past(out_cfg_i.limited_rgb) |->
      (vd_i.red >= 8'd16) && (vd_i.red <= 8'd235) &&
      (vd_i.green >= 8'd16) && (vd_i.green <= 8'd235) &&
      (vd_i.blue >= 8'd16) && (vd_i.blue <= 8'd235))
    else begin
      $error("vd_o channel outside 16..235 in limited range");
      fail_cnt++;
    end

endmodule

bind ppu_range_out ppu_out_asserts u_asserts (
  .VCLK_Tx   (VCLK_Tx),
  .nVRST_Tx  (nVRST_Tx),
  .pix_i     (pix_i),
  .out_cfg_i (out_cfg_i),
  .de_i      (de_o),
  .vd_i      (vd_o)
);

`default_nettype wire

//--- verif/tb_clk_gen.sv
// 40 ns clock from time 0; reset is released 2 ns after the second rising edge
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
  output logic VCLK_Tx,
  output logic nVRST_Tx
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 2;

  initial begin
    VCLK_Tx = 1'b0;
    forever #HALF_PERIOD VCLK_Tx = ~VCLK_Tx;
  end

  // Release lands between edges, same offset as the stimulus
  initial begin
    nVRST_Tx = 1'b0;
    repeat (RST_CYCLES) @(posedge VCLK_Tx);
    #2 nVRST_Tx = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
// Samples on the falling edge; skips 6 cycles after a cfg or PAL change while the mode settles
`default_nettype none
`timescale 1ns/1ns

`include "ppu_out_defines.svh"

module tb_checker
  import ppu_out_pkg::*;
(
  input  logic        VCLK_Tx,
  input  logic        nVRST_Tx,
  input  ppu_cfg_t    cfg_i,
  input  logic        palmode_i,
  input  pix_t        pix_i,
  input  vmode_e      vmode_i,
  input  logic        vsync_i,
  input  logic        hsync_i,
  input  logic        de_i,
  input  rgb_t        vd_i,
  output logic [31:0] err_count_o,
  output logic [31:0] cmp_count_o
);

  localparam int SETTLE_CYC = 6;
  localparam int DEPTH      = `PPU_PIPE_DEPTH;
  localparam int LIM_COEFF  = 220;
  localparam int LIM_OFFSET = 16;

  pix_t     hist [DEPTH];
  int       hist_cnt;
  int       quiet;
  int       edges_out;
  ppu_cfg_t cfg_prev;
  logic     pal_prev;

  initial begin
    err_count_o = 0;
    cmp_count_o = 0;
    hist_cnt    = 0;
    quiet       = 0;
    edges_out   = 0;
  end

  // ============================================================
  // Reference model
  // ============================================================

  function automatic vmode_e model_vmode(input ppu_cfg_t c, input logic pal);
    logic   use_pal;
    vmode_e m;
    if (c.force60 && !c.llm && c.target_res != RES_288P) begin
      use_pal = 1'b0;
    end else if (c.force50 && !c.llm && c.target_res != RES_240P) begin
      use_pal = 1'b1;
    end else begin
      use_pal = pal;
    end
    if (use_pal) begin
      case (c.target_res)
        RES_240P, RES_288P: m = VM_288P50;
        RES_480P, RES_576P: m = VM_576P50;
        RES_720P:           m = VM_720P50;
        RES_960P:           m = VM_960P50;
        RES_1080P:          m = VM_1080P50;
        default:            m = VM_1200P50;
      endcase
    end else begin
      case (c.target_res)
        RES_240P, RES_288P: m = VM_240P60;
        RES_480P, RES_576P: m = c.use_vga ? VM_VGAP60 : VM_480P60;
        RES_720P:           m = VM_720P60;
        RES_960P:           m = VM_960P60;
        RES_1080P:          m = VM_1080P60;
        default:            m = VM_1200P60;
      endcase
    end
    return m;
  endfunction

  // 720p and up use positive syncs
  function automatic logic model_sync_high(input vmode_e m);
    case (m)
      VM_240P60, VM_480P60, VM_VGAP60, VM_288P50, VM_576P50: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  // Round half up of c * 220 / 256, then the offset
  function automatic logic [7:0] model_limited(input logic [7:0] c);
    int unsigned scaled;
    scaled = (32'(c) * LIM_COEFF + 128) / 256;
    return 8'(scaled + LIM_OFFSET);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    cmp_count_o = cmp_count_o + 1;
    if (act !== exp) begin
      err_count_o = err_count_o + 1;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // ============================================================
  // Monitoring
  // ============================================================

  always @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      edges_out = 0;
    end else if (edges_out < 8) begin
      edges_out = edges_out + 1;
    end
  end

  always @(negedge VCLK_Tx) begin
    pix_t   exp_pix;
    vmode_e exp_mode;
    logic   exp_high;
    logic   exp_vs;
    logic   exp_hs;
    rgb_t   exp_vd;
    if (!nVRST_Tx) begin
      quiet    = 0;
      hist_cnt = 0;
      compare("de_o", 32'(1'b0), 32'(de_i));
      compare("vsync_o", 32'(1'b1), 32'(vsync_i));
      compare("hsync_o", 32'(1'b1), 32'(hsync_i));
      compare("vd_o", 32'(24'd0), 32'(vd_i));
    end else begin
      // Still reset-cleared control on the first active edge
      if (edges_out == 1) begin
        compare("de_o", 32'(1'b0), 32'(de_i));
        compare("vsync_o", 32'(1'b1), 32'(vsync_i));
        compare("hsync_o", 32'(1'b1), 32'(hsync_i));
      end
      if (cfg_i !== cfg_prev || palmode_i !== pal_prev) begin
        quiet = 0;
      end else if (quiet < SETTLE_CYC) begin
        quiet++;
      end
      if (quiet >= SETTLE_CYC && hist_cnt >= DEPTH) begin
        exp_pix  = hist[DEPTH-1];
        exp_mode = model_vmode(cfg_i, palmode_i);
        exp_high = model_sync_high(exp_mode);
        exp_vs   = exp_high ? exp_pix.vsync : ~exp_pix.vsync;
        exp_hs   = exp_high ? exp_pix.hsync : ~exp_pix.hsync;
        exp_vd   = exp_pix.color;
        if (cfg_i.limited_rgb) begin
          exp_vd.red   = model_limited(exp_pix.color.red);
          exp_vd.green = model_limited(exp_pix.color.green);
          exp_vd.blue  = model_limited(exp_pix.color.blue);
        end
        compare("vmode_o", 32'(exp_mode), 32'(vmode_i));
        compare("de_o", 32'(exp_pix.de), 32'(de_i));
        compare("vsync_o", 32'(exp_vs), 32'(vsync_i));
        compare("hsync_o", 32'(exp_hs), 32'(hsync_i));
        compare("vd_o", 32'(exp_vd), 32'(vd_i));
      end
      for (int i = DEPTH - 1; i > 0; i--) begin
        hist[i] = hist[i-1];
      end
      hist[0] = pix_i;
      if (hist_cnt < DEPTH) begin
        hist_cnt++;
      end
    end
    cfg_prev = cfg_i;
    pal_prev = palmode_i;
  end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
// Random cfg per 200-cycle segment, random pixel every cycle; assertions need Verilator --assert
`default_nettype none
`timescale 1ns/1ns

`include "ppu_out_defines.svh"

module tb_top
  import ppu_out_pkg::*;
();

  localparam int SEG_COUNT   = 8;
  localparam int SEG_LEN     = 200;
  localparam int DRIVE_DLY   = 2;
  localparam int TIMEOUT_CYC = SEG_COUNT * SEG_LEN + 400;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  ppu_cfg_t    cfg;
  logic        palmode;
  pix_t        pix;
  vmode_e      vmode;
  logic        vsync;
  logic        hsync;
  logic        de;
  rgb_t        vd;
  logic [31:0] chk_errs;
  logic [31:0] chk_cmps;
  logic [31:0] rng_state;
  int          cycle_cnt = 0;

  tb_clk_gen u_clk (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx)
  );

  ppu_out_top u_dut (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .cfg_i     (cfg),
    .palmode_i (palmode),
    .pix_i     (pix),
    .vmode_o   (vmode),
    .vsync_o   (vsync),
    .hsync_o   (hsync),
    .de_o      (de),
    .vd_o      (vd)
  );

  tb_checker u_chk (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .cfg_i       (cfg),
    .palmode_i   (palmode),
    .pix_i       (pix),
    .vmode_i     (vmode),
    .vsync_i     (vsync),
    .hsync_i     (hsync),
    .de_i        (de),
    .vd_i        (vd),
    .err_count_o (chk_errs),
    .cmp_count_o (chk_cmps)
  );

  // ============================================================
  // Random stimulus
  // ============================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drive_pixel();
    rng_state = xorshift32(rng_state);
    pix = pix_t'(rng_state[26:0]);
  endtask

  // Force bits 50/50 each, llm one time in four, range alternates per segment
  task automatic draw_cfg(input int seg);
    rng_state = xorshift32(rng_state);
    cfg.target_res  = target_res_e'(rng_state[2:0]);
    cfg.force60     = rng_state[3];
    cfg.force50     = rng_state[4];
    cfg.llm         = (rng_state[6:5] == 2'b00);
    cfg.use_vga     = rng_state[7];
    cfg.limited_rgb = seg[0];
    palmode         = rng_state[8];
  endtask

  initial begin
    cfg       = '0;
    palmode   = 1'b0;
    pix       = '0;
    rng_state = 32'd99;
    @(posedge nVRST_Tx);
    for (int seg = 0; seg < SEG_COUNT; seg++) begin
      for (int c = 0; c < SEG_LEN; c++) begin
        @(posedge VCLK_Tx);
        #DRIVE_DLY;
        if (c == 0) begin
          draw_cfg(seg);
        end
        drive_pixel();
      end
    end
    repeat (`PPU_PIPE_DEPTH + 3) @(posedge VCLK_Tx);
    $display("Errors: checker %0d, assertions %0d, comparisons made %0d",
             chk_errs, u_dut.u_range_out.u_asserts.fail_cnt, chk_cmps);
    if (chk_errs == 0 && u_dut.u_range_out.u_asserts.fail_cnt == 0 && chk_cmps != 0) begin
      $display("Result: PASSED");
    end else begin
      if (chk_cmps == 0) begin
        $display("No output comparisons were made");
      end
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge VCLK_Tx) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/ppu_out_pkg.sv
rtl/ppu_cfg_decode.sv
rtl/ppu_range_out.sv
rtl/ppu_out_top.sv
verif/ppu_out_asserts.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
# Verilator build and run for the ppu_out_top testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
